// File: common/icache_pkg.sv
package icache_pkg;

   // Default geometry, overridden from the top level
   localparam int FETCH_ADDR_WIDTH = 32;     // Fetch address bits
   localparam int FETCH_DATA_WIDTH = 32;     // Fetch word bits, also the line size
   localparam int NB_WAYS          = 2;      // Associativity
   localparam int CACHE_SIZE       = 256;    // Capacity in bytes

   ////////////////////////////////////////////////////////////////////////////
   // Derived geometry
   ////////////////////////////////////////////////////////////////////////////

   // Rows per way, one word per row
   function automatic int scm_num_rows(int cache_size, int nb_ways, int data_width);
      return cache_size / nb_ways / (data_width / 8);
   endfunction

   function automatic int set_addr_width(int cache_size, int nb_ways, int data_width);
      return $clog2(scm_num_rows(cache_size, nb_ways, data_width));
   endfunction

   function automatic int offset_width(int data_width);
      return $clog2(data_width / 8);         // Byte offset inside the word
   endfunction

   // Full upper address plus the valid bit on top
   function automatic int tag_width(int addr_width, int data_width, int nb_ways,
                                    int cache_size);
      return addr_width - set_addr_width(cache_size, nb_ways, data_width)
             - offset_width(data_width) + 1;
   endfunction

   // Field widths of the address split, fixed at the defaults
   localparam int ADDR_SET_WIDTH    = set_addr_width(CACHE_SIZE, NB_WAYS, FETCH_DATA_WIDTH);
   localparam int ADDR_OFFSET_WIDTH = offset_width(FETCH_DATA_WIDTH);
   localparam int ADDR_TAG_WIDTH    = FETCH_ADDR_WIDTH - ADDR_SET_WIDTH - ADDR_OFFSET_WIDTH;

   // One fetch address, seen flat or split into its cache fields
   typedef union packed {
      logic [FETCH_ADDR_WIDTH-1:0]        raw;
      struct packed {
         logic [ADDR_TAG_WIDTH-1:0]     tag;
         logic [ADDR_SET_WIDTH-1:0]     set_idx;
         logic [ADDR_OFFSET_WIDTH-1:0]  offset;
      } fields;
   } icache_addr_u;

   typedef enum logic [2:0] {
      FLUSH,         // Invalidate every row, one per cycle
      IDLE,
      LOOKUP,        // Tags and data out of the banks, compare
      REFILL_REQ,    // Request held until granted
      REFILL_WAIT,   // Cached refill, allocate on the beat
      BYPASS_WAIT    // Uncached refill, no bank write
   } icache_state_e;

endpackage

// File: icache_mem/icache_bank.sv
`timescale 1ns/100ps

module icache_bank
   import icache_pkg::*;
#(
   parameter int ADDR_WIDTH = set_addr_width(CACHE_SIZE, NB_WAYS, FETCH_DATA_WIDTH),
   parameter int DATA_WIDTH = FETCH_DATA_WIDTH
)
(
   input  logic                    clk,
   input  logic                    req_i,     // Bank selected
   input  logic                    we_i,      // Shared write strobe
   input  logic [ADDR_WIDTH-1:0]   addr_i,
   input  logic [DATA_WIDTH-1:0]   wdata_i,
   output logic [DATA_WIDTH-1:0]   rdata_o    // Valid the cycle after a read
);

   localparam int NUM_ROWS = 2 ** ADDR_WIDTH;

   logic [DATA_WIDTH-1:0]  rows [NUM_ROWS];
   logic                   read_en;
   logic                   write_en;

   assign read_en  = req_i && !we_i;
   assign write_en = req_i && we_i;

   always_ff @(posedge clk)
   begin
      if (write_en)
         rows[addr_i] <= wdata_i;
      if (read_en)
         rdata_o <= rows[addr_i];   // Holds last read otherwise
   end

endmodule

// File: icache_ctrl/icache_way_select.sv
`timescale 1ns/100ps

module icache_way_select
   import icache_pkg::*;
#(
   parameter int    FETCH_ADDR_WIDTH = icache_pkg::FETCH_ADDR_WIDTH,
   parameter int    FETCH_DATA_WIDTH = icache_pkg::FETCH_DATA_WIDTH,
   parameter int    NB_WAYS          = icache_pkg::NB_WAYS,
   parameter int    CACHE_SIZE       = icache_pkg::CACHE_SIZE,
   localparam int   TAG_WIDTH        = tag_width(FETCH_ADDR_WIDTH, FETCH_DATA_WIDTH, NB_WAYS,
                                                 CACHE_SIZE)
)
(
   input  logic                                        clk,
   input  logic                                        rst_n_i,
   input  logic [NB_WAYS-1:0][TAG_WIDTH-1:0]           tag_rdata_i,  // Valid bit on top
   input  logic [NB_WAYS-1:0][FETCH_DATA_WIDTH-1:0]    data_rdata_i,
   input  logic [TAG_WIDTH-2:0]                        lookup_tag_i,
   input  logic                                        alloc_i,
   output logic                                        hit_o,
   output logic [FETCH_DATA_WIDTH-1:0]                 hit_data_o,
   output logic [NB_WAYS-1:0]                          victim_way_o  // One-hot
);

   localparam int PTR_WIDTH = (NB_WAYS > 1) ? $clog2(NB_WAYS) : 1;

   logic [NB_WAYS-1:0]    way_hit;
   logic [PTR_WIDTH-1:0]  victim_ptr_q;           // Shared by all sets

   // Compare and OR-mux, at most one way hits
   always_comb
   begin
      hit_data_o = '0;
      for (int w = 0; w < NB_WAYS; w++)
      begin
         way_hit[w] = tag_rdata_i[w][TAG_WIDTH-1] &&
                      (tag_rdata_i[w][TAG_WIDTH-2:0] == lookup_tag_i);
         if (way_hit[w])
            hit_data_o = hit_data_o | data_rdata_i[w];
      end
   end

   assign hit_o = |way_hit;

   always_comb
   begin
      victim_way_o               = '0;
      victim_way_o[victim_ptr_q] = 1'b1;
   end

   // Round-robin, one step per allocated line
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         victim_ptr_q <= '0;
      else if (alloc_i)
         victim_ptr_q <= (victim_ptr_q == PTR_WIDTH'(NB_WAYS - 1)) ? '0 : victim_ptr_q + 1'b1;
   end

endmodule

// File: icache_ctrl/icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl
   import icache_pkg::*;
#(
   parameter int    FETCH_ADDR_WIDTH = icache_pkg::FETCH_ADDR_WIDTH,
   parameter int    FETCH_DATA_WIDTH = icache_pkg::FETCH_DATA_WIDTH,
   parameter int    NB_WAYS          = icache_pkg::NB_WAYS,
   parameter int    CACHE_SIZE       = icache_pkg::CACHE_SIZE,
   localparam int   SCM_NUM_ROWS     = scm_num_rows(CACHE_SIZE, NB_WAYS, FETCH_DATA_WIDTH),
   localparam int   SET_ADDR_WIDTH   = set_addr_width(CACHE_SIZE, NB_WAYS, FETCH_DATA_WIDTH),
   localparam int   OFFSET_WIDTH     = offset_width(FETCH_DATA_WIDTH),
   localparam int   TAG_WIDTH        = tag_width(FETCH_ADDR_WIDTH, FETCH_DATA_WIDTH, NB_WAYS,
                                                 CACHE_SIZE)
)
(
   input  logic                          clk,
   input  logic                          rst_n_i,

   input  logic                          fetch_req_i,
   input  logic [FETCH_ADDR_WIDTH-1:0]   fetch_addr_i,
   input  logic                          bypass_icache_i,
   input  logic                          flush_icache_i,
   input  logic                          refill_gnt_i,
   input  logic                          resp_valid_i,     // From the response buffer
   input  logic [FETCH_DATA_WIDTH-1:0]   resp_data_i,
   input  logic                          hit_i,
   input  logic [FETCH_DATA_WIDTH-1:0]   hit_data_i,
   input  logic [NB_WAYS-1:0]            victim_way_i,     // One-hot

   output logic                          fetch_gnt_o,
   output logic                          fetch_rvalid_o,
   output logic [FETCH_DATA_WIDTH-1:0]   fetch_rdata_o,
   output logic                          refill_req_o,
   output logic [FETCH_ADDR_WIDTH-1:0]   refill_addr_o,
   output logic                          cache_is_bypassed_o,
   output logic                          cache_is_flushed_o,

   // Bank control, one row address for tags and data
   output logic [NB_WAYS-1:0]            tag_req_o,
   output logic [NB_WAYS-1:0]            data_req_o,
   output logic                          bank_we_o,
   output logic [SET_ADDR_WIDTH-1:0]     row_addr_o,
   output logic [TAG_WIDTH-1:0]          tag_wdata_o,
   output logic [FETCH_DATA_WIDTH-1:0]   data_wdata_o,
   output logic [TAG_WIDTH-2:0]          lookup_tag_o,
   output logic                          alloc_o           // Victim pointer advance
);

   localparam logic [SET_ADDR_WIDTH-1:0] LAST_ROW = SET_ADDR_WIDTH'(SCM_NUM_ROWS - 1);

   icache_state_e               state_q, state_d;
   icache_addr_u                fetch_addr_u;      // Incoming address, split
   icache_addr_u                addr_q;            // Address under service
   icache_addr_u                line_addr;         // Word-aligned refill address
   logic [SET_ADDR_WIDTH-1:0]   flush_row_q;
   logic                        flushed_q;
   logic                        bypass_q;          // Current fetch skips the banks
   logic                        hit_rvalid_q;
   logic [FETCH_DATA_WIDTH-1:0] hit_rdata_q;
   logic                        refill_done;       // Beat leaves the buffer

   assign fetch_addr_u.raw = fetch_addr_i;

   always_comb
   begin
      line_addr              = addr_q;
      line_addr.fields.offset = {OFFSET_WIDTH{1'b0}};
   end

   assign refill_req_o        = (state_q == REFILL_REQ);
   assign refill_addr_o       = line_addr.raw;    // Stable while waiting for grant
   assign lookup_tag_o        = addr_q.fields.tag;
   assign data_wdata_o        = resp_data_i;
   assign cache_is_bypassed_o = (state_q == IDLE) && bypass_icache_i;
   assign cache_is_flushed_o  = flushed_q;

   // Hit data comes a cycle after LOOKUP, refill data straight through
   assign refill_done    = resp_valid_i && (state_q == REFILL_WAIT || state_q == BYPASS_WAIT);
   assign fetch_rvalid_o = hit_rvalid_q || refill_done;
   assign fetch_rdata_o  = refill_done ? resp_data_i : hit_rdata_q;

   ////////////////////////////////////////////////////////////////////////////
   // Next state and bank control
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      state_d     = state_q;
      fetch_gnt_o = 1'b0;
      tag_req_o   = '0;
      data_req_o  = '0;
      bank_we_o   = 1'b0;
      alloc_o     = 1'b0;
      row_addr_o  = addr_q.fields.set_idx;
      tag_wdata_o = {1'b1, addr_q.fields.tag};       // Valid line on allocation

      case (state_q)
         FLUSH:
         begin
            tag_req_o   = '1;                        // All ways at once
            bank_we_o   = 1'b1;
            row_addr_o  = flush_row_q;
            tag_wdata_o = '0;                        // Valid bit cleared
            if (flush_row_q == LAST_ROW)
               state_d = IDLE;
         end

         IDLE:
         begin
            row_addr_o = fetch_addr_u.fields.set_idx;
            if (flush_icache_i)
               state_d = FLUSH;                      // Flush wins over a fetch
            else if (fetch_req_i)
            begin
               fetch_gnt_o = 1'b1;
               if (bypass_icache_i)
                  state_d = REFILL_REQ;
               else
               begin
                  tag_req_o  = '1;                   // Read all ways in the grant cycle
                  data_req_o = '1;
                  state_d    = LOOKUP;
               end
            end
         end

         LOOKUP:
            state_d = hit_i ? IDLE : REFILL_REQ;

         REFILL_REQ:
         begin
            if (refill_gnt_i)
               state_d = bypass_q ? BYPASS_WAIT : REFILL_WAIT;
         end

         REFILL_WAIT:
         begin
            if (resp_valid_i)
            begin
               tag_req_o  = victim_way_i;
               data_req_o = victim_way_i;
               bank_we_o  = 1'b1;
               alloc_o    = 1'b1;
               state_d    = IDLE;
            end
         end

         BYPASS_WAIT:
         begin
            if (resp_valid_i)
               state_d = IDLE;
         end

         default:
            state_d = FLUSH;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // State registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         state_q      <= FLUSH;                      // Banks come up with random tags
         flush_row_q  <= '0;
         flushed_q    <= 1'b0;
         bypass_q     <= 1'b0;
         hit_rvalid_q <= 1'b0;
      end
      else
      begin
         state_q      <= state_d;
         hit_rvalid_q <= (state_q == LOOKUP) && hit_i;

         if (state_q == FLUSH)
            flush_row_q <= (flush_row_q == LAST_ROW) ? '0 : flush_row_q + 1'b1;

         if (state_q == FLUSH && state_d == IDLE)
            flushed_q <= 1'b1;
         else if (state_q == IDLE && flush_icache_i)
            flushed_q <= 1'b0;
         else if (alloc_o)
            flushed_q <= 1'b0;                       // First line back in

         if (fetch_gnt_o)
            bypass_q <= bypass_icache_i;
      end
   end

   // Payload
   always_ff @(posedge clk)
   begin
      if (fetch_gnt_o)
         addr_q <= fetch_addr_u;
      if (state_q == LOOKUP)
         hit_rdata_q <= hit_data_i;
   end

endmodule

// File: verilog/refill_resp_buffer.sv
`timescale 1ns/100ps

module refill_resp_buffer
   import icache_pkg::*;
#(
   parameter int DATA_WIDTH = FETCH_DATA_WIDTH
)
(
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    valid_i,    // Memory beat, always taken
   input  logic [DATA_WIDTH-1:0]   data_i,
   output logic                    valid_o,    // Popped in the same cycle
   output logic [DATA_WIDTH-1:0]   data_o
);

   logic [DATA_WIDTH-1:0]   fifo_mem [2];
   logic                    wr_ptr_q;
   logic                    rd_ptr_q;
   logic [1:0]              count_q;           // Entries held, 0 to 2
   logic                    push;
   logic                    pop;

   assign push    = valid_i;
   assign pop     = (count_q != 2'd0);        // Consumer never stalls
   assign valid_o = pop;
   assign data_o  = fifo_mem[rd_ptr_q];

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         count_q  <= 2'd0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= ~wr_ptr_q;
         if (pop)
            rd_ptr_q <= ~rd_ptr_q;
         count_q <= count_q + 2'(push) - 2'(pop);
      end
   end

   // Storage
   always_ff @(posedge clk)
   begin
      if (push)
         fifo_mem[wr_ptr_q] <= data_i;
   end

endmodule

// File: verilog/pri_icache.sv
`timescale 1ns/100ps

module pri_icache
   import icache_pkg::*;
#(
   parameter int FETCH_ADDR_WIDTH = icache_pkg::FETCH_ADDR_WIDTH,
   parameter int FETCH_DATA_WIDTH = icache_pkg::FETCH_DATA_WIDTH,
   parameter int NB_WAYS          = icache_pkg::NB_WAYS,
   parameter int CACHE_SIZE       = icache_pkg::CACHE_SIZE
)
(
   input  logic                          clk,
   input  logic                          rst_n_i,

   // Core fetch port
   input  logic                          fetch_req_i,
   input  logic [FETCH_ADDR_WIDTH-1:0]   fetch_addr_i,
   output logic                          fetch_gnt_o,
   output logic                          fetch_rvalid_o,
   output logic [FETCH_DATA_WIDTH-1:0]   fetch_rdata_o,

   // Refill port towards memory
   output logic                          refill_req_o,
   input  logic                          refill_gnt_i,
   output logic [FETCH_ADDR_WIDTH-1:0]   refill_addr_o,
   input  logic                          refill_r_valid_i,
   input  logic [FETCH_DATA_WIDTH-1:0]   refill_r_data_i,

   input  logic                          bypass_icache_i,
   output logic                          cache_is_bypassed_o,
   input  logic                          flush_icache_i,
   output logic                          cache_is_flushed_o
);

   localparam int SET_ADDR_WIDTH = set_addr_width(CACHE_SIZE, NB_WAYS, FETCH_DATA_WIDTH);
   localparam int TAG_WIDTH      = tag_width(FETCH_ADDR_WIDTH, FETCH_DATA_WIDTH, NB_WAYS,
                                             CACHE_SIZE);

   // Bank side of the controller
   logic [NB_WAYS-1:0]                          tag_req;
   logic [NB_WAYS-1:0]                          data_req;
   logic                                        bank_we;          // Shared by tags and data
   logic [SET_ADDR_WIDTH-1:0]                   row_addr;
   logic [TAG_WIDTH-1:0]                        tag_wdata;
   logic [FETCH_DATA_WIDTH-1:0]                 data_wdata;
   logic [NB_WAYS-1:0][TAG_WIDTH-1:0]           tag_rdata;
   logic [NB_WAYS-1:0][FETCH_DATA_WIDTH-1:0]    data_rdata;

   // Way selection
   logic [TAG_WIDTH-2:0]                        lookup_tag;
   logic                                        alloc;
   logic                                        hit;
   logic [FETCH_DATA_WIDTH-1:0]                 hit_data;
   logic [NB_WAYS-1:0]                          victim_way;    // One-hot

   // Buffered refill response
   logic                                        resp_valid;
   logic [FETCH_DATA_WIDTH-1:0]                 resp_data;

   ////////////////////////////////////////////////////////////////////////////
   // Controller and hit/victim logic
   ////////////////////////////////////////////////////////////////////////////

   icache_ctrl
   #(
      .FETCH_ADDR_WIDTH    ( FETCH_ADDR_WIDTH    ),
      .FETCH_DATA_WIDTH    ( FETCH_DATA_WIDTH    ),
      .NB_WAYS             ( NB_WAYS             ),
      .CACHE_SIZE          ( CACHE_SIZE          )
   )
   i_icache_ctrl
   (
      .clk                 ( clk                 ),
      .rst_n_i             ( rst_n_i             ),
      .fetch_req_i         ( fetch_req_i         ),
      .fetch_addr_i        ( fetch_addr_i        ),
      .bypass_icache_i     ( bypass_icache_i     ),
      .flush_icache_i      ( flush_icache_i      ),
      .refill_gnt_i        ( refill_gnt_i        ),
      .resp_valid_i        ( resp_valid          ),
      .resp_data_i         ( resp_data           ),
      .hit_i               ( hit                 ),
      .hit_data_i          ( hit_data            ),
      .victim_way_i        ( victim_way          ),
      .fetch_gnt_o         ( fetch_gnt_o         ),
      .fetch_rvalid_o      ( fetch_rvalid_o      ),
      .fetch_rdata_o       ( fetch_rdata_o       ),
      .refill_req_o        ( refill_req_o        ),
      .refill_addr_o       ( refill_addr_o       ),
      .cache_is_bypassed_o ( cache_is_bypassed_o ),
      .cache_is_flushed_o  ( cache_is_flushed_o  ),
      .tag_req_o           ( tag_req             ),
      .data_req_o          ( data_req            ),
      .bank_we_o           ( bank_we             ),
      .row_addr_o          ( row_addr            ),
      .tag_wdata_o         ( tag_wdata           ),
      .data_wdata_o        ( data_wdata          ),
      .lookup_tag_o        ( lookup_tag          ),
      .alloc_o             ( alloc               )
   );

   icache_way_select
   #(
      .FETCH_ADDR_WIDTH    ( FETCH_ADDR_WIDTH    ),
      .FETCH_DATA_WIDTH    ( FETCH_DATA_WIDTH    ),
      .NB_WAYS             ( NB_WAYS             ),
      .CACHE_SIZE          ( CACHE_SIZE          )
   )
   i_icache_way_select
   (
      .clk                 ( clk                 ),
      .rst_n_i             ( rst_n_i             ),
      .tag_rdata_i         ( tag_rdata           ),
      .data_rdata_i        ( data_rdata          ),
      .lookup_tag_i        ( lookup_tag          ),
      .alloc_i             ( alloc               ),
      .hit_o               ( hit                 ),
      .hit_data_o          ( hit_data            ),
      .victim_way_o        ( victim_way          )
   );

   ////////////////////////////////////////////////////////////////////////////
   // Way banks
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < NB_WAYS; i++)
   begin : gen_tag_way
      icache_bank
      #(
         .ADDR_WIDTH ( SET_ADDR_WIDTH ),
         .DATA_WIDTH ( TAG_WIDTH      )
      )
      i_tag_bank
      (
         .clk        ( clk            ),
         .req_i      ( tag_req[i]     ),
         .we_i       ( bank_we        ),
         .addr_i     ( row_addr       ),
         .wdata_i    ( tag_wdata      ),
         .rdata_o    ( tag_rdata[i]   )
      );
   end

   for (genvar i = 0; i < NB_WAYS; i++)
   begin : gen_data_way
      icache_bank
      #(
         .ADDR_WIDTH ( SET_ADDR_WIDTH   ),
         .DATA_WIDTH ( FETCH_DATA_WIDTH )
      )
      i_data_bank
      (
         .clk        ( clk              ),
         .req_i      ( data_req[i]      ),
         .we_i       ( bank_we          ),
         .addr_i     ( row_addr         ),
         .wdata_i    ( data_wdata       ),
         .rdata_o    ( data_rdata[i]    )
      );
   end

   // Memory beats land here, never back-pressured
   refill_resp_buffer
   #(
      .DATA_WIDTH ( FETCH_DATA_WIDTH )
   )
   i_refill_resp_buffer
   (
      .clk        ( clk              ),
      .rst_n_i    ( rst_n_i          ),
      .valid_i    ( refill_r_valid_i ),
      .data_i     ( refill_r_data_i  ),
      .valid_o    ( resp_valid       ),
      .data_o     ( resp_data        )
   );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen
#(
   parameter int PERIOD_NS    = 4,     // Full clock period
   parameter int RESET_CYCLES = 5      // Rising edges with reset held low
)
(
   output logic clk_o,
   output logic rst_n_o
);

   initial
   begin
      clk_o = 1'b0;
      forever
         #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Synchronous reset, released just after an edge like every other input
   initial
   begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1 rst_n_o = 1'b1;
   end

endmodule

// File: verification/tb_pri_icache.sv
`timescale 1ns/100ps

module tb_pri_icache;

   localparam int ADDR_WIDTH = 32;
   localparam int DATA_WIDTH = 32;
   localparam int NB_WAYS    = 2;
   localparam int CACHE_SIZE = 256;
   localparam int NUM_ROWS   = CACHE_SIZE / NB_WAYS / (DATA_WIDTH / 8);   // Rows per way
   localparam logic [31:0] DATA_KEY = 32'hA5A5_0000;   // Memory word is address XOR key

   localparam int OP_FETCH      = 0;
   localparam int OP_BYPASS_ON  = 1;
   localparam int OP_BYPASS_OFF = 2;
   localparam int OP_FLUSH      = 3;

   logic                    clk;
   logic                    rst_n;
   logic                    fetch_req, fetch_gnt, fetch_rvalid;
   logic [ADDR_WIDTH-1:0]   fetch_addr;
   logic [DATA_WIDTH-1:0]   fetch_rdata;
   logic                    refill_req, refill_gnt, refill_r_valid;
   logic [ADDR_WIDTH-1:0]   refill_addr;
   logic [DATA_WIDTH-1:0]   refill_r_data;
   logic                    bypass, is_bypassed, flush, is_flushed;

   int            pat_op[$];
   logic [31:0]   pat_addr[$];
   logic          pat_miss[$];
   int            error_count   = 0;
   int            failed_tests  = 0;
   int            refill_count  = 0;     // Granted refills seen by the memory model
   logic [31:0]   last_refill_addr;
   int            grant_count   = 0;
   int            rvalid_count  = 0;
   int            cycle_count   = 0;
   int            timeout_limit = 0;     // Zero until the patterns are loaded
   logic          first_fetch   = 1'b1;

   tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(5)) i_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

   pri_icache
   #(
      .FETCH_ADDR_WIDTH ( ADDR_WIDTH ),
      .FETCH_DATA_WIDTH ( DATA_WIDTH ),
      .NB_WAYS          ( NB_WAYS    ),
      .CACHE_SIZE       ( CACHE_SIZE )
   )
   uut
   (
      .clk                 ( clk            ),
      .rst_n_i             ( rst_n          ),
      .fetch_req_i         ( fetch_req      ),
      .fetch_addr_i        ( fetch_addr     ),
      .fetch_gnt_o         ( fetch_gnt      ),
      .fetch_rvalid_o      ( fetch_rvalid   ),
      .fetch_rdata_o       ( fetch_rdata    ),
      .refill_req_o        ( refill_req     ),
      .refill_gnt_i        ( refill_gnt     ),
      .refill_addr_o       ( refill_addr    ),
      .refill_r_valid_i    ( refill_r_valid ),
      .refill_r_data_i     ( refill_r_data  ),
      .bypass_icache_i     ( bypass         ),
      .cache_is_bypassed_o ( is_bypassed    ),
      .flush_icache_i      ( flush          ),
      .cache_is_flushed_o  ( is_flushed     )
   );

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("[FAIL] %0t ns %s expected 0x%08h actual 0x%08h",
                  $time, name, expected, actual);
         error_count++;
      end
   endtask

   task automatic next_drive_slot();
      @(posedge clk);
      #1;                                         // Inputs change 1 ns after the edge
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Memory model, random grant and response delays
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      int          delay;
      logic [31:0] req_addr;
      void'($urandom(95));                        // One seed for the whole run
      refill_gnt     = 1'b0;
      refill_r_valid = 1'b0;
      refill_r_data  = '0;
      forever
      begin
         next_drive_slot();
         if (refill_req)
         begin
            req_addr = refill_addr;
            delay    = $urandom_range(3, 0);
            repeat (delay) next_drive_slot();
            check_value("refill_addr_o", req_addr, refill_addr);   // Held until grant
            check_value("refill_req_o", 32'd1, 32'(refill_req));
            refill_gnt = 1'b1;
            next_drive_slot();
            refill_gnt       = 1'b0;
            refill_count++;
            last_refill_addr = req_addr;
            delay            = $urandom_range(4, 1);
            repeat (delay - 1) next_drive_slot();
            refill_r_valid = 1'b1;
            refill_r_data  = req_addr ^ DATA_KEY;
            next_drive_slot();
            refill_r_valid = 1'b0;
         end
      end
   end

   // One rvalid per grant, counted where outputs are stable
   always @(negedge clk)
   begin
      if (rst_n && fetch_req && fetch_gnt)
         grant_count++;
      if (rst_n && fetch_rvalid)
         rvalid_count++;
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (timeout_limit > 0 && cycle_count >= timeout_limit)
      begin
         $display("Timeout: run still busy after %0d cycles, a handshake never ended",
                  cycle_count);
         $display("Regression failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Operations
   ////////////////////////////////////////////////////////////////////////////

   task automatic fetch_and_check(input logic [31:0] addr, input logic exp_miss);
      logic [31:0] line_addr;
      int          refills_before;
      int          latency;
      logic        done;
      line_addr = {addr[31:2], 2'b00};
      next_drive_slot();
      fetch_req  = 1'b1;
      fetch_addr = addr;
      @(negedge clk);
      while (!fetch_gnt)
         @(negedge clk);                          // Held off during flush
      if (first_fetch)
         check_value("cache_is_flushed_o", 32'd1, 32'(is_flushed));
      first_fetch    = 1'b0;
      refills_before = refill_count;
      latency        = 0;
      done           = 1'b0;
      while (!done)
      begin
         next_drive_slot();
         fetch_req = 1'b0;
         @(negedge clk);
         latency++;
         done = fetch_rvalid;
      end
      check_value("fetch_rdata_o", line_addr ^ DATA_KEY, fetch_rdata);
      check_value("refill_req_o", 32'(exp_miss), 32'(refill_count != refills_before));
      if (exp_miss)
         check_value("refill_addr_o", line_addr, last_refill_addr);
      else
         check_value("fetch_rvalid_o latency", 32'd2, 32'(latency));   // Fixed hit path
   endtask

   task automatic set_bypass(input logic value);
      next_drive_slot();
      bypass = value;
      @(negedge clk);
      check_value("cache_is_bypassed_o", 32'(value), 32'(is_bypassed));
   endtask

   task automatic flush_and_wait();
      int flush_len;
      next_drive_slot();
      flush = 1'b1;
      @(negedge clk);
      flush_len = 0;
      do
      begin
         next_drive_slot();
         flush = 1'b0;
         @(negedge clk);
         if (!is_flushed)
            flush_len++;
      end
      while (!is_flushed);
      check_value("flush cycles", 32'(NUM_ROWS), 32'(flush_len));   // One row per cycle
   endtask

   task automatic load_patterns(output logic ok);
      int          fd;
      int          op;
      logic [31:0] addr;
      int          miss;
      string       line;
      fd = $fopen("verification/icache_patterns.txt", "r");
      ok = 1'b0;
      if (fd != 0)
      begin
         while ($fgets(line, fd))
         begin
            if ($sscanf(line, "%h %h %h", op, addr, miss) == 3)   // Comment lines skipped
            begin
               pat_op.push_back(op);
               pat_addr.push_back(addr);
               pat_miss.push_back(miss[0]);
            end
         end
         $fclose(fd);
         ok = (pat_op.size() > 0);
      end
   endtask

   task automatic apply_pattern(input int idx);
      int    errors_before;
      string op_name;
      errors_before = error_count;
      case (pat_op[idx])
         OP_FETCH:
         begin
            op_name = "fetch";
            fetch_and_check(pat_addr[idx], pat_miss[idx]);
         end
         OP_BYPASS_ON:
         begin
            op_name = "bypass on";
            set_bypass(1'b1);
         end
         OP_BYPASS_OFF:
         begin
            op_name = "bypass off";
            set_bypass(1'b0);
         end
         OP_FLUSH:
         begin
            op_name = "flush";
            flush_and_wait();
         end
         default:
         begin
            op_name = "unknown";
            $display("Pattern %0d has an unknown operation code %0d", idx, pat_op[idx]);
            error_count++;
         end
      endcase
      if (error_count != errors_before)
         failed_tests++;
      $display("test %0d %s addr 0x%08h exp_miss %0d: %s", idx, op_name, pat_addr[idx],
               pat_miss[idx], (error_count == errors_before) ? "ok" : "mismatch");
   endtask

   initial
   begin
      logic loaded;
      fetch_req  = 1'b0;
      fetch_addr = '0;
      bypass     = 1'b0;
      flush      = 1'b0;
      load_patterns(loaded);
      if (!loaded)
      begin
         $display("Could not read any pattern from verification/icache_patterns.txt");
         $display("Regression failed");
         $finish;
      end
      else
      begin
         timeout_limit = pat_op.size() * 20 + NUM_ROWS * 2 + 50;
         @(posedge rst_n);
         for (int i = 0; i < pat_op.size(); i++)
            apply_pattern(i);
         next_drive_slot();                       // Let the rvalid counter settle
         check_value("fetch_rvalid_o count", 32'(grant_count), 32'(rvalid_count));
         $display("Summary: %0d tests, %0d failed, %0d mismatches",
                  pat_op.size(), failed_tests, error_count);
         if (error_count == 0)
            $display("Regression passed");
         else
            $display("Regression failed");
         $finish;
      end
   end

endmodule

// File: verification/icache_patterns.txt
# op (0 fetch, 1 bypass on, 2 bypass off, 3 flush)  address (hex)  expected miss (1 miss, 0 hit)
# Refill data is the word-aligned address XOR A5A50000, set index is address bits 6:2
# First fetch after reset, unaligned, then repeats on the same word
0 00001002 1
0 00001000 0
0 00001004 1
0 00001004 0
0 00001006 0
# Three lines in set 2, the global victim pointer alternates ways
0 00002008 1
0 00002088 1
0 00002108 1
0 00002088 0
0 00002108 0
0 00002008 1
0 00002108 0
0 00001000 0
0 00001004 0
# Bypass refills every fetch and allocates nothing
1 00000000 0
0 00003010 1
0 00003010 1
0 00001000 1
2 00000000 0
0 00003010 1
0 00003010 0
0 00001000 0
# Flush invalidates all lines
3 00000000 0
0 00001000 1
0 00001004 1
0 00002108 1
0 00003010 1
0 00002108 0
0 00001000 0
0 00001004 0
# Top of the address space, two tags in set 31
0 FFFFFFFC 1
0 7FFFFFFC 1
0 FFFFFFFF 0
0 7FFFFFFC 0
0 00003010 0

// File: project.f
common/icache_pkg.sv
icache_mem/icache_bank.sv
icache_ctrl/icache_way_select.sv
icache_ctrl/icache_ctrl.sv
verilog/refill_resp_buffer.sv
verilog/pri_icache.sv
verification/tb_clock_gen.sv
verification/tb_pri_icache.sv

// File: Bender.yml
package:
  name: pri_icache

sources:
  # Design, in compile order
  - files:
      - common/icache_pkg.sv
      - icache_mem/icache_bank.sv
      - icache_ctrl/icache_way_select.sv
      - icache_ctrl/icache_ctrl.sv
      - verilog/refill_resp_buffer.sv
      - verilog/pri_icache.sv

  # Testbench, top module tb_pri_icache
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_pri_icache.sv
